// ==== project.f ====
periph_xbar_pkg.sv
periph_req_demux.sv
periph_rr_arbiter.sv
periph_resp_router.sv
periph_error_slave.sv
periph_xbar.sv
tb_clock_gen.sv
tb_periph_xbar_properties.sv
tb_periph_xbar.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build with Verilator, run, and decide on the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_periph_xbar -f project.f -o sim_xbar \
  && ./obj_dir/sim_xbar > sim.log 2>&1 || echo "Build or run failed"
cat sim.log 2>/dev/null
grep -qx "RESULT: PASS" sim.log && exit 0 || exit 1

// ==== tb_periph_xbar.sv ====
// Peripheral model and crossbar testbench with reference decode, reference memory,
// compare process and reporting.
`timescale 1ns/1ns

module tb_periph_model #(
  parameter int PORT = 0
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       req_i,
  input  logic [31:0]                addr_i,
  input  logic                       wen_i,
  input  logic [31:0]                wdata_i,
  input  logic [3:0]                 be_i,
  input  logic [3:0]                 id_i,
  output logic                       gnt_o,
  output logic                       r_valid_o,
  output logic [31:0]                r_rdata_o,
  output logic [3:0]                 r_id_o,
  output periph_xbar_pkg::resp_opc_e r_opc_o
);

  logic [31:0] mem [256];
  logic [31:0] rdata_q;
  logic [3:0]  id_q;
  logic        xfer_q;
  int          stall;
  int          seed;

  initial begin
    seed      = 10;
    gnt_o     = 1'b0;
    r_valid_o = 1'b0;
    r_rdata_o = '0;
    r_id_o    = '0;
    r_opc_o   = periph_xbar_pkg::OPC_OK;
    for (int w = 0; w < 256; w++) begin
      mem[w] = 32'hC0DE_0000 | (PORT << 12) | w;
    end
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      stall  <= 0;
      xfer_q <= 1'b0;
    end else begin
      xfer_q <= req_i & gnt_o;
      if (req_i && gnt_o) begin
        rdata_q <= mem[addr_i[9:2]];
        id_q    <= id_i;
        stall   <= $unsigned($random(seed)) % 3;
        for (int b = 0; b < 4; b++) begin
          if (!wen_i && be_i[b]) mem[addr_i[9:2]][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end else if (req_i && stall > 0) begin
        stall <= stall - 1;
      end
    end
  end

  // Response one cycle after the transfer.
  always @(negedge clk_i) begin
    gnt_o     <= !reset_i && stall == 0;
    r_valid_o <= xfer_q;
    r_rdata_o <= rdata_q;
    r_id_o    <= id_q;
  end

endmodule

module tb_periph_xbar;

  logic clk;
  logic reset;
  logic [3:0]       init_req;
  logic [3:0][31:0] init_addr;
  logic [3:0]       init_wen;
  logic [3:0][31:0] init_wdata;
  logic [3:0][3:0]  init_be;
  logic [3:0]       init_gnt;
  logic [3:0]       init_r_valid;
  logic [3:0][31:0] init_r_rdata;
  periph_xbar_pkg::resp_opc_e [3:0] init_r_opc;
  logic [4:0]       tgt_req;
  logic [4:0][31:0] tgt_addr;
  logic [4:0]       tgt_wen;
  logic [4:0][31:0] tgt_wdata;
  logic [4:0][3:0]  tgt_be;
  logic [4:0][3:0]  tgt_id;
  logic [4:0]       tgt_gnt;
  logic [4:0]       tgt_r_valid;
  logic [4:0][31:0] tgt_r_rdata;
  logic [4:0][3:0]  tgt_r_id;
  periph_xbar_pkg::resp_opc_e [4:0] tgt_r_opc;

  // Reference memory and the expectation of each initiator's open transaction.
  logic [31:0] ref_mem [5][256];
  logic [31:0] exp_data [4];
  periph_xbar_pkg::resp_opc_e exp_opc [4];
  logic exp_rd [4];
  logic exp_pending [4];
  int   exp_cycle [4];
  int   last_port [4];
  int   req_cnt [4];
  int   resp_cnt [4];
  int   fair_log [$];
  logic fair_on;
  int   cycle_cnt;
  int   errors;
  int   tests;
  int   seed;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) u_clk (.clk_o(clk), .reset_o(reset));

  periph_xbar #(.NB_INIT(4), .NB_TARGETS(4)) u_dut (
    .clk_i(clk), .reset_i(reset),
    .init_req_i(init_req), .init_addr_i(init_addr), .init_wen_i(init_wen),
    .init_wdata_i(init_wdata), .init_be_i(init_be), .init_gnt_o(init_gnt),
    .init_r_valid_o(init_r_valid), .init_r_rdata_o(init_r_rdata), .init_r_opc_o(init_r_opc),
    .tgt_req_o(tgt_req), .tgt_addr_o(tgt_addr), .tgt_wen_o(tgt_wen),
    .tgt_wdata_o(tgt_wdata), .tgt_be_o(tgt_be), .tgt_id_o(tgt_id), .tgt_gnt_i(tgt_gnt),
    .tgt_r_valid_i(tgt_r_valid), .tgt_r_rdata_i(tgt_r_rdata), .tgt_r_id_i(tgt_r_id),
    .tgt_r_opc_i(tgt_r_opc)
  );

  for (genvar p = 0; p < 5; p++) begin : gen_model
    tb_periph_model #(.PORT(p)) u_model (
      .clk_i(clk), .reset_i(reset), .req_i(tgt_req[p]), .addr_i(tgt_addr[p]),
      .wen_i(tgt_wen[p]), .wdata_i(tgt_wdata[p]), .be_i(tgt_be[p]), .id_i(tgt_id[p]),
      .gnt_o(tgt_gnt[p]), .r_valid_o(tgt_r_valid[p]), .r_rdata_o(tgt_r_rdata[p]),
      .r_id_o(tgt_r_id[p]), .r_opc_o(tgt_r_opc[p])
    );
  end

  // Port 4 is external and 5 is the error responder.
  function automatic int expected_port(input logic [31:0] a);
    if (a[31:24] != periph_xbar_pkg::CLUSTER_BASE) return 4;
    if (a[23:20] == periph_xbar_pkg::PERIPH_REGION && a[19:14] == 6'd0 && a[13:10] < 4) begin
      return int'(a[13:10]);
    end
    return 5;
  endfunction

  function automatic logic [31:0] local_addr(input int idx, input logic [7:0] word);
    return {8'h10, 4'h2, 6'h00, 4'(idx), word, 2'b00};
  endfunction

  // Records the port of each transfer and checks its decode.
  always @(posedge clk) begin
    for (int p = 0; p < 5; p++) begin
      if (!reset && tgt_req[p] && tgt_gnt[p]) begin
        assert (expected_port(tgt_addr[p]) == p) else begin
          $display("Fail at %0t: address %h appeared on port %0d", $time, tgt_addr[p], p);
          errors++;
        end
        for (int i = 0; i < 4; i++) begin
          if (tgt_id[p][i]) begin
            last_port[i] = p;
            if (p == 0 && fair_on) fair_log.push_back(i);
          end
        end
      end
    end
  end

  // Compare process for every response.
  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (!reset && init_r_valid[i]) begin
        assert (exp_pending[i]) else begin
          $display("Initiator %0d received a response it did not ask for", i);
          errors++;
        end
        if (exp_rd[i]) begin
          assert (init_r_rdata[i] == exp_data[i]) else begin
            $display("Fail at %0t: initiator %0d rdata %h, expected %h", $time, i,
                     init_r_rdata[i], exp_data[i]);
            errors++;
          end
        end
        assert (init_r_opc[i] == exp_opc[i]) else begin
          $display("Fail at %0t: initiator %0d wrong opcode", $time, i);
          errors++;
        end
        if (exp_cycle[i] >= 0) begin
          assert (cycle_cnt == exp_cycle[i]) else begin
            $display("Fail at %0t: initiator %0d error response in wrong cycle", $time, i);
            errors++;
          end
        end
        exp_pending[i] = 1'b0;
        resp_cnt[i]    = resp_cnt[i] + 1;
      end
    end
    cycle_cnt = cycle_cnt + 1;
  end

  task automatic do_txn(input int i, input logic [31:0] addr, input logic wr,
                        input logic [31:0] wdata, input logic [3:0] be);
    int port;
    int cnt;
    int resp_before;
    port = expected_port(addr);
    @(negedge clk);
    init_addr[i]  = addr;
    init_wen[i]   = ~wr;
    init_wdata[i] = wdata;
    init_be[i]    = be;
    init_req[i]   = 1'b1;
    last_port[i]  = 5;
    resp_before   = resp_cnt[i];
    cnt = 0;
    @(posedge clk);
    while (!init_gnt[i] && cnt < 50) begin
      cnt++;
      @(posedge clk);
    end
    if (!init_gnt[i]) begin
      $display("Timeout: initiator %0d was never granted", i);
      errors++;
    end
    @(negedge clk);
    init_req[i]    = 1'b0;
    exp_rd[i]      = !wr || port == 5;
    exp_data[i]    = (port == 5) ? 32'h0 : ref_mem[port][addr[9:2]];
    exp_opc[i]     = (port == 5) ? periph_xbar_pkg::OPC_ERR : periph_xbar_pkg::OPC_OK;
    exp_cycle[i]   = (port == 5) ? cycle_cnt : -1;
    exp_pending[i] = 1'b1;
    req_cnt[i]++;
    for (int b = 0; b < 4; b++) begin
      if (wr && port < 5 && be[b]) ref_mem[port][addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
    end
    cnt = 0;
    while (resp_cnt[i] == resp_before && cnt < 50) begin
      cnt++;
      @(negedge clk);
    end
    if (resp_cnt[i] == resp_before) begin
      $display("Timeout: initiator %0d received no response", i);
      errors++;
    end
    assert (last_port[i] == port) else begin
      $display("Fail at %0t: initiator %0d reached port %0d, expected %0d", $time, i,
               last_port[i], port);
      errors++;
    end
  endtask

  task automatic run_random(input int i);
    logic [31:0] addr;
    logic [7:0]  word;
    int          kind;
    for (int n = 0; n < 200; n++) begin
      kind = $unsigned($random(seed)) % 4;
      word = {2'(i), 6'($random(seed))};
      if (kind < 2) addr = local_addr($unsigned($random(seed)) % 4, word);
      else if (kind == 2) addr = {8'h40 + 8'($random(seed) & 7), 14'h0, word, 2'b00};
      else addr = {8'h10, 4'($random(seed)), 10'($random(seed)), word, 2'b00};
      do_txn(i, addr, $random(seed) & 1, $random(seed), 4'($random(seed)) | 4'h1);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    $display("Test %s finished with %0d errors", name, errors - errors_before);
  endtask

  initial begin
    int e0;
    int cnt;
    seed = 10;
    errors = 0;
    tests = 0;
    cycle_cnt = 0;
    fair_on = 1'b0;
    init_req = '0;
    init_addr = '0;
    init_wen = '1;
    init_wdata = '0;
    init_be = '0;
    for (int i = 0; i < 4; i++) begin
      exp_pending[i] = 1'b0;
      exp_rd[i] = 1'b0;
      req_cnt[i] = 0;
      resp_cnt[i] = 0;
      last_port[i] = 5;
    end
    for (int p = 0; p < 5; p++) begin
      for (int w = 0; w < 256; w++) ref_mem[p][w] = 32'hC0DE_0000 | (p << 12) | w;
    end
    cnt = 0;
    while (reset !== 1'b0 && cnt < 100) begin
      cnt++;
      @(negedge clk);
    end
    if (reset !== 1'b0) begin
      $display("Timeout: reset was never released");
      errors++;
    end
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      for (int p = 0; p < 4; p++) begin
        do_txn(i, local_addr(p, {2'(i), 6'(p)}), 1'b1, $random(seed), 4'hF);
        do_txn(i, local_addr(p, {2'(i), 6'(p)}), 1'b1, $random(seed), 4'b0101);
        do_txn(i, local_addr(p, {2'(i), 6'(p)}), 1'b0, 32'h0, 4'hF);
      end
    end
    report_test("local_routing", e0);
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      do_txn(i, {8'h40 + 8'(i), 14'h3A5, 2'(i), 6'h11, 2'b00}, 1'b1, $random(seed), 4'hF);
      do_txn(i, {8'h40 + 8'(i), 14'h3A5, 2'(i), 6'h11, 2'b00}, 1'b0, 32'h0, 4'hF);
    end
    report_test("external_routing", e0);
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      do_txn(i, local_addr(4 + i, 8'h01), 1'b0, 32'h0, 4'hF);
      do_txn(i, {8'h10, 4'h2, 6'h01, 4'h0, 8'h02, 2'b00}, 1'b1, 32'h1234, 4'hF);
      do_txn(i, {8'h10, 4'h3 + 4'(i), 6'h00, 4'h1, 8'h03, 2'b00}, 1'b0, 32'h0, 4'hF);
    end
    report_test("error_decode", e0);
    e0 = errors;
    fair_on = 1'b1;
    fork
      for (int n = 0; n < 8; n++) do_txn(0, local_addr(0, 8'h03), 1'b0, 32'h0, 4'hF);
      for (int n = 0; n < 8; n++) do_txn(1, local_addr(0, 8'h43), 1'b0, 32'h0, 4'hF);
      for (int n = 0; n < 8; n++) do_txn(2, local_addr(0, 8'h83), 1'b0, 32'h0, 4'hF);
      for (int n = 0; n < 8; n++) do_txn(3, local_addr(0, 8'hC3), 1'b0, 32'h0, 4'hF);
    join
    fair_on = 1'b0;
    assert (fair_log.size() == 32) else begin
      $display("Fairness test saw %0d transfers instead of 32", fair_log.size());
      errors++;
    end
    // Any four consecutive grants must name four different initiators.
    for (int k = 0; k + 3 < fair_log.size(); k++) begin
      assert (((1 << fair_log[k]) | (1 << fair_log[k+1]) | (1 << fair_log[k+2]) |
               (1 << fair_log[k+3])) == 4'hF) else begin
        $display("Fail at %0t: unfair grant order at transfer %0d", $time, k);
        errors++;
      end
    end
    report_test("fairness", e0);
    e0 = errors;
    fork
      run_random(0);
      run_random(1);
      run_random(2);
      run_random(3);
    join
    for (int i = 0; i < 4; i++) begin
      assert (resp_cnt[i] == req_cnt[i]) else begin
        $display("Initiator %0d got %0d responses for %0d requests", i, resp_cnt[i],
                 req_cnt[i]);
        errors++;
      end
    end
    report_test("random_traffic", e0);
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb_periph_xbar_properties.sv ====
// Handshake assertions for the crossbar ports that are bound into periph_xbar.
`timescale 1ns/1ns

module tb_periph_xbar_properties #(
  parameter int NB_INIT    = 4,
  parameter int NB_TARGETS = 4
) (
  input logic                             clk_i,
  input logic                             reset_i,
  input logic [NB_INIT-1:0]               init_req_i,
  input logic [NB_INIT-1:0]               init_gnt_o,
  input logic [NB_INIT-1:0]               init_r_valid_o,
  input logic [NB_TARGETS:0]              tgt_req_o,
  input logic [NB_TARGETS:0]              tgt_gnt_i,
  input logic [NB_TARGETS:0][NB_INIT-1:0] tgt_id_o
);

  // Set by a grant, cleared by the matching response.
  logic [NB_INIT-1:0] outstanding_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= (outstanding_q | init_gnt_o) & ~init_r_valid_o;
    end
  end

  for (genvar i = 0; i < NB_INIT; i++) begin : gen_init_chk
    assert property (@(posedge clk_i) disable iff (reset_i) init_gnt_o[i] |-> init_req_i[i])
      else $error("Grant without request on initiator %0d", i);
    assert property (@(posedge clk_i) disable iff (reset_i)
                     init_r_valid_o[i] |-> outstanding_q[i])
      else $error("Response without earlier grant on initiator %0d", i);
  end

  // A port transfer carries exactly one id, and that initiator sees its grant.
  for (genvar p = 0; p <= NB_TARGETS; p++) begin : gen_port_chk
    assert property (@(posedge clk_i) disable iff (reset_i)
                     (tgt_req_o[p] && tgt_gnt_i[p]) |-> $onehot(tgt_id_o[p] & init_gnt_o))
      else $error("Port %0d transfer without a grant to exactly one initiator", p);
  end

endmodule

bind periph_xbar tb_periph_xbar_properties #(
  .NB_INIT    (NB_INIT),
  .NB_TARGETS (NB_TARGETS)
) u_props (.*);

// ==== tb_clock_gen.sv ====
// Testbench clock and synchronous reset generator.
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== periph_xbar.sv ====
// Peripheral crossbar top level with per-initiator demux and response router,
// per-port round-robin arbiters and the internal error responder.
`timescale 1ns/1ns

module periph_xbar #(
  parameter int NB_INIT     = 4,
  parameter int NB_TARGETS  = 4,
  parameter int ADDR_WIDTH  = 32,
  parameter int DATA_WIDTH  = 32,
  parameter int ROUTING_LSB = 10,
  parameter int ROUTING_MSB = 13
) (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  // Initiator side.
  input  logic [NB_INIT-1:0]                          init_req_i,
  input  logic [NB_INIT-1:0][ADDR_WIDTH-1:0]          init_addr_i,
  input  logic [NB_INIT-1:0]                          init_wen_i,
  input  logic [NB_INIT-1:0][DATA_WIDTH-1:0]          init_wdata_i,
  input  logic [NB_INIT-1:0][DATA_WIDTH/8-1:0]        init_be_i,
  output logic [NB_INIT-1:0]                          init_gnt_o,
  output logic [NB_INIT-1:0]                          init_r_valid_o,
  output logic [NB_INIT-1:0][DATA_WIDTH-1:0]          init_r_rdata_o,
  output periph_xbar_pkg::resp_opc_e [NB_INIT-1:0]    init_r_opc_o,
  // Target side, local ports then the external port.
  output logic [NB_TARGETS:0]                         tgt_req_o,
  output logic [NB_TARGETS:0][ADDR_WIDTH-1:0]         tgt_addr_o,
  output logic [NB_TARGETS:0]                         tgt_wen_o,
  output logic [NB_TARGETS:0][DATA_WIDTH-1:0]         tgt_wdata_o,
  output logic [NB_TARGETS:0][DATA_WIDTH/8-1:0]       tgt_be_o,
  output logic [NB_TARGETS:0][NB_INIT-1:0]            tgt_id_o,
  input  logic [NB_TARGETS:0]                         tgt_gnt_i,
  input  logic [NB_TARGETS:0]                         tgt_r_valid_i,
  input  logic [NB_TARGETS:0][DATA_WIDTH-1:0]         tgt_r_rdata_i,
  input  logic [NB_TARGETS:0][NB_INIT-1:0]            tgt_r_id_i,
  input  periph_xbar_pkg::resp_opc_e [NB_TARGETS:0]   tgt_r_opc_i
);

  localparam int NB_DST   = NB_TARGETS + 2;
  localparam int ERR_IDX  = NB_TARGETS + 1;

  // Request and grant matrices, initiator-major and destination-major.
  logic [NB_INIT-1:0][NB_DST-1:0] demux_req;
  logic [NB_INIT-1:0][NB_DST-1:0] demux_gnt;
  logic [NB_DST-1:0][NB_INIT-1:0] arb_req;
  logic [NB_DST-1:0][NB_INIT-1:0] arb_gnt;

  // Error responder side of its arbiter.
  logic                           err_req;
  logic                           err_gnt;
  logic [NB_INIT-1:0]             err_id;

  // Responses of all destinations, error responder last.
  logic [NB_DST-1:0]                        rsp_valid;
  logic [NB_DST-1:0][NB_INIT-1:0]           rsp_id;
  logic [NB_DST-1:0][DATA_WIDTH-1:0]        rsp_rdata;
  periph_xbar_pkg::resp_opc_e [NB_DST-1:0]  rsp_opc;

  for (genvar i = 0; i < NB_INIT; i++) begin : gen_init
    periph_req_demux #(
      .NB_TARGETS  (NB_TARGETS),
      .ADDR_WIDTH  (ADDR_WIDTH),
      .ROUTING_LSB (ROUTING_LSB),
      .ROUTING_MSB (ROUTING_MSB)
    ) u_demux (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .req_i     (init_req_i[i]),
      .addr_i    (init_addr_i[i]),
      .gnt_o     (init_gnt_o[i]),
      .dst_req_o (demux_req[i]),
      .dst_gnt_i (demux_gnt[i])
    );

    periph_resp_router #(
      .NB_INIT    (NB_INIT),
      .NB_DST     (NB_DST),
      .DATA_WIDTH (DATA_WIDTH),
      .INIT_IDX   (i)
    ) u_router (
      .r_valid_i (rsp_valid),
      .r_id_i    (rsp_id),
      .r_rdata_i (rsp_rdata),
      .r_opc_i   (rsp_opc),
      .r_valid_o (init_r_valid_o[i]),
      .r_rdata_o (init_r_rdata_o[i]),
      .r_opc_o   (init_r_opc_o[i])
    );
  end

  for (genvar d = 0; d < NB_DST; d++) begin : gen_transpose
    for (genvar i = 0; i < NB_INIT; i++) begin : gen_bit
      assign arb_req[d][i]   = demux_req[i][d];
      assign demux_gnt[i][d] = arb_gnt[d][i];
    end
  end

  // One arbiter per local port and one for the external port.
  for (genvar p = 0; p <= NB_TARGETS; p++) begin : gen_port
    periph_rr_arbiter #(
      .NB_INIT    (NB_INIT),
      .ADDR_WIDTH (ADDR_WIDTH),
      .DATA_WIDTH (DATA_WIDTH)
    ) u_arb (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (arb_req[p]),
      .gnt_o   (arb_gnt[p]),
      .addr_i  (init_addr_i),
      .wen_i   (init_wen_i),
      .wdata_i (init_wdata_i),
      .be_i    (init_be_i),
      .req_o   (tgt_req_o[p]),
      .gnt_i   (tgt_gnt_i[p]),
      .addr_o  (tgt_addr_o[p]),
      .wen_o   (tgt_wen_o[p]),
      .wdata_o (tgt_wdata_o[p]),
      .be_o    (tgt_be_o[p]),
      .id_o    (tgt_id_o[p])
    );

    assign rsp_valid[p] = tgt_r_valid_i[p];
    assign rsp_id[p]    = tgt_r_id_i[p];
    assign rsp_rdata[p] = tgt_r_rdata_i[p];
    assign rsp_opc[p]   = tgt_r_opc_i[p];
  end

  // The error responder only needs the id, the payload fields stay open.
  periph_rr_arbiter #(
    .NB_INIT    (NB_INIT),
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_err_arb (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (arb_req[ERR_IDX]),
    .gnt_o   (arb_gnt[ERR_IDX]),
    .addr_i  (init_addr_i),
    .wen_i   (init_wen_i),
    .wdata_i (init_wdata_i),
    .be_i    (init_be_i),
    .req_o   (err_req),
    .gnt_i   (err_gnt),
    .addr_o  (),
    .wen_o   (),
    .wdata_o (),
    .be_o    (),
    .id_o    (err_id)
  );

  periph_error_slave #(
    .NB_INIT (NB_INIT)
  ) u_err_slave (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (err_req),
    .id_i      (err_id),
    .gnt_o     (err_gnt),
    .r_valid_o (rsp_valid[ERR_IDX]),
    .r_id_o    (rsp_id[ERR_IDX]),
    .r_opc_o   (rsp_opc[ERR_IDX])
  );

  // Error responses carry no data.
  assign rsp_rdata[ERR_IDX] = '0;

endmodule

// ==== periph_error_slave.sv ====
// Error responder for undecoded peripheral addresses.
`timescale 1ns/1ns

module periph_error_slave #(
  parameter int NB_INIT = 4
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       req_i,
  input  logic [NB_INIT-1:0]         id_i,
  output logic                       gnt_o,
  output logic                       r_valid_o,
  output logic [NB_INIT-1:0]         r_id_o,
  output periph_xbar_pkg::resp_opc_e r_opc_o
);

  logic               r_valid_q;
  logic [NB_INIT-1:0] r_id_q;

  // Always ready, so every request is a transfer.
  assign gnt_o = req_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      r_id_q <= id_i;
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_id_o    = r_id_q;
  assign r_opc_o   = periph_xbar_pkg::OPC_ERR;

endmodule

// ==== periph_resp_router.sv ====
// Response selection for one initiator by one-hot id match.
`timescale 1ns/1ns

module periph_resp_router #(
  parameter int NB_INIT    = 4,
  parameter int NB_DST     = 6,
  parameter int DATA_WIDTH = 32,
  parameter int INIT_IDX   = 0
) (
  input  logic [NB_DST-1:0]                        r_valid_i,
  input  logic [NB_DST-1:0][NB_INIT-1:0]           r_id_i,
  input  logic [NB_DST-1:0][DATA_WIDTH-1:0]        r_rdata_i,
  input  periph_xbar_pkg::resp_opc_e [NB_DST-1:0]  r_opc_i,
  output logic                                     r_valid_o,
  output logic [DATA_WIDTH-1:0]                    r_rdata_o,
  output periph_xbar_pkg::resp_opc_e               r_opc_o
);

  localparam int                 SEL_W = (NB_DST > 1) ? $clog2(NB_DST) : 1;
  localparam logic [NB_INIT-1:0] MY_ID = NB_INIT'(1) << INIT_IDX;

  logic [NB_DST-1:0] hit;
  logic [SEL_W-1:0]  sel;

  for (genvar d = 0; d < NB_DST; d++) begin : gen_hit
    assign hit[d] = r_valid_i[d] & (r_id_i[d] == MY_ID);
  end

  // At most one destination answers this initiator per cycle, so OR-ing
  // the indices of the hits gives the binary index.
  always_comb begin
    sel = '0;
    for (int d = 0; d < NB_DST; d++) begin
      if (hit[d]) begin
        sel = sel | SEL_W'(d);
      end
    end
  end

  assign r_valid_o = |hit;
  assign r_rdata_o = r_rdata_i[sel];
  assign r_opc_o   = r_opc_i[sel];

endmodule

// ==== periph_rr_arbiter.sv ====
// Round-robin arbiter for one destination port with request field
// forwarding and one-hot initiator id.
`timescale 1ns/1ns

module periph_rr_arbiter #(
  parameter int NB_INIT    = 4,
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic [NB_INIT-1:0]                   req_i,
  output logic [NB_INIT-1:0]                   gnt_o,
  input  logic [NB_INIT-1:0][ADDR_WIDTH-1:0]   addr_i,
  input  logic [NB_INIT-1:0]                   wen_i,
  input  logic [NB_INIT-1:0][DATA_WIDTH-1:0]   wdata_i,
  input  logic [NB_INIT-1:0][DATA_WIDTH/8-1:0] be_i,
  output logic                                 req_o,
  input  logic                                 gnt_i,
  output logic [ADDR_WIDTH-1:0]                addr_o,
  output logic                                 wen_o,
  output logic [DATA_WIDTH-1:0]                wdata_o,
  output logic [DATA_WIDTH/8-1:0]              be_o,
  output logic [NB_INIT-1:0]                   id_o
);

  localparam int IDX_W = (NB_INIT > 1) ? $clog2(NB_INIT) : 1;

  logic [IDX_W-1:0] ptr_q;
  logic [IDX_W-1:0] rr_idx;
  logic [IDX_W-1:0] sel_idx;
  logic [IDX_W-1:0] lock_idx_q;
  logic             rr_found;
  logic             locked_q;
  logic             xfer;

  // First requester at or after the pointer, wrapping around.
  always_comb begin
    int cand;
    rr_found = 1'b0;
    rr_idx   = ptr_q;
    for (int k = 0; k < NB_INIT; k++) begin
      cand = (int'(ptr_q) + k) % NB_INIT;
      if (!rr_found && req_i[cand]) begin
        rr_found = 1'b1;
        rr_idx   = IDX_W'(cand);
      end
    end
  end

  // A stalled winner stays selected until the port grants it.
  assign sel_idx = locked_q ? lock_idx_q : rr_idx;
  assign req_o   = locked_q ? req_i[sel_idx] : rr_found;
  assign xfer    = req_o & gnt_i;

  assign id_o  = NB_INIT'(1) << sel_idx;
  assign gnt_o = xfer ? id_o : '0;

  assign addr_o  = addr_i[sel_idx];
  assign wen_o   = wen_i[sel_idx];
  assign wdata_o = wdata_i[sel_idx];
  assign be_o    = be_i[sel_idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q      <= '0;
      locked_q   <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      locked_q   <= req_o & ~gnt_i;
      lock_idx_q <= sel_idx;
      // Pointer moves just past the winner, only on a transfer.
      if (xfer) begin
        if (int'(sel_idx) == NB_INIT - 1) begin
          ptr_q <= '0;
        end else begin
          ptr_q <= sel_idx + 1'b1;
        end
      end
    end
  end

endmodule

// ==== periph_req_demux.sv ====
// Address decoder and request steering for one initiator.
`timescale 1ns/1ns

module periph_req_demux #(
  parameter int NB_TARGETS  = 4,
  parameter int ADDR_WIDTH  = 32,
  parameter int ROUTING_LSB = 10,
  parameter int ROUTING_MSB = 13
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  output logic                  gnt_o,
  output logic [NB_TARGETS+1:0] dst_req_o,
  input  logic [NB_TARGETS+1:0] dst_gnt_i
);

  localparam int NB_DST  = NB_TARGETS + 2;
  localparam int DST_W   = $clog2(NB_DST);
  localparam int LOCAL_W = ROUTING_MSB - ROUTING_LSB + 1;

  periph_xbar_pkg::decode_kind_e kind;
  logic [LOCAL_W-1:0]            local_idx;
  logic [DST_W-1:0]              dec_idx;
  logic [DST_W-1:0]              sel_idx;
  logic [DST_W-1:0]              held_idx_q;
  logic                          pending_q;

  assign local_idx = addr_i[ROUTING_MSB:ROUTING_LSB];

  // Outside the cluster goes external, holes in the peripheral region go to the error port.
  always_comb begin
    if (addr_i[31:24] != periph_xbar_pkg::CLUSTER_BASE) begin
      kind = periph_xbar_pkg::DEC_EXT;
    end else if (addr_i[23:20] == periph_xbar_pkg::PERIPH_REGION &&
                 addr_i[19:ROUTING_MSB+1] == '0 &&
                 int'(local_idx) < NB_TARGETS) begin
      kind = periph_xbar_pkg::DEC_LOCAL;
    end else begin
      kind = periph_xbar_pkg::DEC_ERR;
    end
  end

  // Local ports first, then the external port, then the error responder.
  always_comb begin
    case (kind)
      periph_xbar_pkg::DEC_LOCAL: dec_idx = DST_W'(local_idx);
      periph_xbar_pkg::DEC_EXT:   dec_idx = DST_W'(NB_TARGETS);
      default:                    dec_idx = DST_W'(NB_TARGETS + 1);
    endcase
  end

  // A waiting request keeps the destination it decoded to in its first cycle.
  assign sel_idx = pending_q ? held_idx_q : dec_idx;

  always_comb begin
    dst_req_o          = '0;
    dst_req_o[sel_idx] = req_i;
  end

  assign gnt_o = req_i & dst_gnt_i[sel_idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= req_i & ~gnt_o;
    end
  end

  always_ff @(posedge clk_i) begin
    held_idx_q <= sel_idx;
  end

endmodule

// ==== periph_xbar_pkg.sv ====
// Shared decode and response enums plus the cluster address map
// for the peripheral crossbar.
package periph_xbar_pkg;

  // Class of destination that a request address decodes to.
  typedef enum logic [1:0] {
    DEC_LOCAL = 2'd0,
    DEC_EXT   = 2'd1,
    DEC_ERR   = 2'd2
  } decode_kind_e;

  // Response opcode returned with every r_valid.
  typedef enum logic {
    OPC_OK  = 1'b0,
    OPC_ERR = 1'b1
  } resp_opc_e;

  // Address bits 31:24 that select this cluster.
  localparam logic [7:0] CLUSTER_BASE = 8'h10;

  // Address bits 23:20 that select the peripheral region inside the cluster.
  localparam logic [3:0] PERIPH_REGION = 4'h2;

endpackage
